/* sim/decode_ref_model.svh */
`ifndef DECODE_REF_MODEL_SVH
`define DECODE_REF_MODEL_SVH

// reference decode written against the raw rv32im encodings

function automatic logic [31:0] ref_imm(input logic [31:0] i);
  logic [2:0] f3;
  f3 = i[14:12];
  case (i[6:0])
    7'h13: begin
      if (f3 == 3'b001 || f3 == 3'b101) begin
        // shift-immediate, shamt only
        ref_imm = {27'd0, i[24:20]};
      end else begin
        ref_imm = 32'($signed(i[31:20]));
      end
    end
    7'h03, 7'h67: ref_imm = 32'($signed(i[31:20]));
    7'h23:        ref_imm = 32'($signed({i[31:25], i[11:7]}));
    7'h63:        ref_imm = 32'($signed({i[31], i[7], i[30:25], i[11:8], 1'b0}));
    7'h37, 7'h17: ref_imm = {i[31:12], 12'd0};
    7'h6f:        ref_imm = 32'($signed({i[31], i[19:12], i[20], i[30:21], 1'b0}));
    default:      ref_imm = '0;
  endcase
endfunction

function automatic rv_decode_pkg::alu_op_t ref_alu_op(input logic [31:0] i);
  ref_alu_op = rv_decode_pkg::ALU_ADD;
  if (i[6:0] == 7'h33 || i[6:0] == 7'h13) begin
    case (i[14:12])
      3'd0: begin
        if (i[6:0] == 7'h33 && i[30]) begin
          ref_alu_op = rv_decode_pkg::ALU_SUB;
        end
      end
      3'd1: ref_alu_op = rv_decode_pkg::ALU_SLL;
      3'd2: ref_alu_op = rv_decode_pkg::ALU_SLT;
      3'd3: ref_alu_op = rv_decode_pkg::ALU_SLTU;
      3'd4: ref_alu_op = rv_decode_pkg::ALU_XOR;
      3'd5: ref_alu_op = i[30] ? rv_decode_pkg::ALU_SRA : rv_decode_pkg::ALU_SRL;
      3'd6: ref_alu_op = rv_decode_pkg::ALU_OR;
      3'd7: ref_alu_op = rv_decode_pkg::ALU_AND;
    endcase
  end
endfunction

function automatic rv_decode_pkg::fu_type_t ref_fu(input logic [31:0] i);
  ref_fu = rv_decode_pkg::FU_ALU;
  if (i[6:0] == 7'h33 && i[31:25] == 7'h01) begin
    ref_fu = i[14] ? rv_decode_pkg::FU_DIV : rv_decode_pkg::FU_MUL;
  end
endfunction

function automatic logic ref_illegal(input logic [31:0] i);
  case (i[6:0])
    7'h33:   ref_illegal = i[25] && (i[31:25] != 7'h01);
    7'h03, 7'h0f, 7'h13, 7'h17, 7'h23,
    7'h37, 7'h63, 7'h67, 7'h6f, 7'h73:
             ref_illegal = 1'b0;
    default: ref_illegal = 1'b1;
  endcase
endfunction

function automatic rv_decode_pkg::csr_op_t ref_csr_op(input logic [31:0] i);
  ref_csr_op = rv_decode_pkg::CSR_NONE;
  if (i[6:0] == 7'h73) begin
    case (i[13:12])
      2'd1:    ref_csr_op = rv_decode_pkg::CSR_SWAP;
      2'd2:    ref_csr_op = rv_decode_pkg::CSR_SET;
      2'd3:    ref_csr_op = rv_decode_pkg::CSR_CLR;
      default: ref_csr_op = rv_decode_pkg::CSR_NONE;
    endcase
  end
endfunction

function automatic rv_decode_pkg::priv_op_t ref_priv(input logic [31:0] i);
  ref_priv = rv_decode_pkg::PRIV_NONE;
  if (i[6:0] == 7'h73 && i[14:12] == 3'b000) begin
    case (i[31:20])
      12'h000: ref_priv = rv_decode_pkg::PRIV_ECALL;
      12'h001: ref_priv = rv_decode_pkg::PRIV_EBREAK;
      12'h105: ref_priv = rv_decode_pkg::PRIV_WFI;
      12'h302: ref_priv = rv_decode_pkg::PRIV_MRET;
      default: ref_priv = rv_decode_pkg::PRIV_NONE;
    endcase
  end
endfunction

function automatic logic ref_wen(input logic [31:0] i);
  logic writes;
  case (i[6:0])
    7'h03, 7'h13, 7'h17, 7'h33, 7'h37, 7'h67, 7'h6f: writes = 1'b1;
    // system writes only for csr access
    7'h73:   writes = (ref_csr_op(i) != rv_decode_pkg::CSR_NONE);
    default: writes = 1'b0;
  endcase
  ref_wen = writes && !ref_illegal(i);
endfunction

function automatic rv_decode_pkg::w_src_t ref_w_src(input logic [31:0] i);
  case (i[6:0])
    7'h03:        ref_w_src = rv_decode_pkg::WB_LOAD;
    7'h67, 7'h6f: ref_w_src = rv_decode_pkg::WB_PC4;
    7'h37:        ref_w_src = rv_decode_pkg::WB_IMM;
    7'h73:        ref_w_src = rv_decode_pkg::WB_CSR;
    default:      ref_w_src = rv_decode_pkg::WB_ALU;
  endcase
endfunction

`endif

/* sim/tb_decode_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_decode_top;

  localparam int unsigned DIV_LAT = 4;
  localparam int N_ALU = 48;
  localparam int N_IMM = 8;
  // reset, random blocks, dispatch, system and illegal sections
  localparam int STIM_CYCLES = 16 + N_ALU + 8 * N_IMM + 4 * DIV_LAT + 24 + 10 + 6;
  localparam int TIMEOUT_CYCLES = 2 * STIM_CYCLES;
  localparam logic [6:0] IMM_OPS [8] = '{7'h03, 7'h23, 7'h63, 7'h6f, 7'h67, 7'h37,
                                         7'h17, 7'h13};

  logic CLK;
  logic rst_n_i;
  logic [31:0] instr_i;
  logic instr_valid_i;
  logic valid_o;
  rv_decode_pkg::alu_op_t alu_op_o;
  rv_decode_pkg::fu_type_t fu_type_o;
  rv_decode_pkg::w_src_t w_src_o;
  logic wen_o;
  logic [4:0] rs1_o;
  logic [4:0] rs2_o;
  logic [4:0] rd_o;
  logic [31:0] imm_o;
  rv_decode_pkg::csr_op_t csr_op_o;
  logic csr_imm_o;
  rv_decode_pkg::priv_op_t priv_op_o;
  logic illegal_o;
  logic halt_o;
  logic alu_issue_o;
  logic mul_issue_o;
  logic div_issue_o;
  logic stall_o;

  int errors = 0;
  int sent = 0;
  int cycles = 0;
  logic [31:0] rng;

  // expected pipeline state
  logic [31:0] cur_instr = '0;
  logic cur_valid;
  int unsigned div_left;
  rv_decode_pkg::fu_type_t cur_fu;
  logic exp_busy;
  logic exp_stall;
  logic exp_alu;
  logic exp_mul;
  logic exp_div;

  `include "decode_ref_model.svh"

  decode_top #(
    .HALT_ON_SELF_JUMP(1'b1),
    .DIV_LATENCY      (DIV_LAT)
  ) decode_top_inst (.*);

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x ^ (x << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] expected);
    errors++;
    $display("FAIL %s got %h expected %h", name, got, expected);
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge CLK);
      #1;
    end
  endtask

  // present one instruction and hold it until the dispatcher lets it in
  task automatic send(input logic [31:0] instr);
    logic stalled;
    instr_i = instr;
    instr_valid_i = 1'b1;
    sent++;
    do begin
      stalled = stall_o;
      @(posedge CLK);
      #1;
    end while (stalled);
    instr_valid_i = 1'b0;
  endtask

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  assign cur_fu = ref_fu(cur_instr);
  assign exp_busy = (div_left != 0);
  assign exp_stall = cur_valid && (cur_fu != rv_decode_pkg::FU_ALU) && exp_busy;
  assign exp_alu = cur_valid && (cur_fu == rv_decode_pkg::FU_ALU);
  assign exp_mul = cur_valid && (cur_fu == rv_decode_pkg::FU_MUL) && !exp_busy;
  assign exp_div = cur_valid && (cur_fu == rv_decode_pkg::FU_DIV) && !exp_busy;

  always @(posedge CLK) begin
    if (!rst_n_i) begin
      cur_valid <= 1'b0;
      div_left <= 0;
    end else begin
      if (exp_div) begin
        div_left <= DIV_LAT;
      end else if (exp_busy) begin
        div_left <= div_left - 1;
      end
      if (!exp_stall) begin
        cur_valid <= instr_valid_i;
        if (instr_valid_i) begin
          cur_instr <= instr_i;
        end
      end
    end
  end

  valid_a: assert property (@(posedge CLK) disable iff (!rst_n_i) valid_o == cur_valid)
    else report_mismatch("valid_o", $sampled(valid_o), $sampled(cur_valid));
  stall_a: assert property (@(posedge CLK) disable iff (!rst_n_i) stall_o == exp_stall)
    else report_mismatch("stall_o", $sampled(stall_o), $sampled(exp_stall));
  issue_a: assert property (@(posedge CLK) disable iff (!rst_n_i)
    {alu_issue_o, mul_issue_o, div_issue_o} == {exp_alu, exp_mul, exp_div})
    else report_mismatch("alu/mul/div_issue_o",
                         $sampled({alu_issue_o, mul_issue_o, div_issue_o}),
                         $sampled({exp_alu, exp_mul, exp_div}));
  fu_a: assert property (@(posedge CLK) disable iff (!rst_n_i)
    cur_valid |-> fu_type_o == cur_fu)
    else report_mismatch("fu_type_o", $sampled(fu_type_o), $sampled(cur_fu));
  alu_op_a: assert property (@(posedge CLK) disable iff (!rst_n_i)
    cur_valid && cur_fu == rv_decode_pkg::FU_ALU |-> alu_op_o == ref_alu_op(cur_instr))
    else report_mismatch("alu_op_o", $sampled(alu_op_o), ref_alu_op($sampled(cur_instr)));
  regs_a: assert property (@(posedge CLK) disable iff (!rst_n_i)
    cur_valid |-> {rs1_o, rs2_o, rd_o} == {cur_instr[19:15], cur_instr[24:20], cur_instr[11:7]})
    else report_mismatch("rs1_o/rs2_o/rd_o", $sampled({rs1_o, rs2_o, rd_o}),
                         $sampled({cur_instr[19:15], cur_instr[24:20], cur_instr[11:7]}));
  imm_a: assert property (@(posedge CLK) disable iff (!rst_n_i)
    cur_valid |-> imm_o == ref_imm(cur_instr))
    else report_mismatch("imm_o", $sampled(imm_o), ref_imm($sampled(cur_instr)));
  // bubbles must keep the write enable low as well
  wen_a: assert property (@(posedge CLK) disable iff (!rst_n_i)
    wen_o == (cur_valid && ref_wen(cur_instr)))
    else report_mismatch("wen_o", $sampled(wen_o),
                         $sampled(cur_valid) && ref_wen($sampled(cur_instr)));
  w_src_a: assert property (@(posedge CLK) disable iff (!rst_n_i)
    cur_valid && ref_wen(cur_instr) |-> w_src_o == ref_w_src(cur_instr))
    else report_mismatch("w_src_o", $sampled(w_src_o), ref_w_src($sampled(cur_instr)));
  csr_a: assert property (@(posedge CLK) disable iff (!rst_n_i)
    cur_valid |-> csr_op_o == ref_csr_op(cur_instr))
    else report_mismatch("csr_op_o", $sampled(csr_op_o), ref_csr_op($sampled(cur_instr)));
  csr_imm_a: assert property (@(posedge CLK) disable iff (!rst_n_i)
    cur_valid && ref_csr_op(cur_instr) != rv_decode_pkg::CSR_NONE |->
    csr_imm_o == cur_instr[14])
    else report_mismatch("csr_imm_o", $sampled(csr_imm_o), $sampled(cur_instr[14]));
  priv_a: assert property (@(posedge CLK) disable iff (!rst_n_i)
    cur_valid |-> priv_op_o == ref_priv(cur_instr))
    else report_mismatch("priv_op_o", $sampled(priv_op_o), ref_priv($sampled(cur_instr)));
  illegal_a: assert property (@(posedge CLK) disable iff (!rst_n_i)
    cur_valid |-> illegal_o == ref_illegal(cur_instr))
    else report_mismatch("illegal_o", $sampled(illegal_o), ref_illegal($sampled(cur_instr)));
  halt_a: assert property (@(posedge CLK) disable iff (!rst_n_i)
    cur_valid |-> halt_o == (cur_instr == 32'h0000_006f))
    else report_mismatch("halt_o", $sampled(halt_o), $sampled(cur_instr == 32'h0000_006f));

  always @(posedge CLK) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles with %0d errors", cycles, errors);
      $display("tests failed");
      $finish;
    end
  end

  initial begin
    logic [2:0] f3;
    logic [6:0] f7;
    int stall_cycles;
    rst_n_i = 1'b0;
    instr_i = '0;
    instr_valid_i = 1'b0;
    rng = 32'd55444;
    repeat (16) @(posedge CLK);
    #1;
    assert ({valid_o, alu_issue_o, mul_issue_o, div_issue_o, stall_o, wen_o, halt_o,
             illegal_o} == 8'h00)
      else report_mismatch("reset outputs", {valid_o, alu_issue_o, mul_issue_o,
                           div_issue_o, stall_o, wen_o, halt_o, illegal_o}, 32'h0);
    rst_n_i = 1'b1;
    idle(1);

    // random reg-reg and reg-imm alu instructions
    repeat (N_ALU) begin
      rng = xorshift32(rng);
      f3 = rng[14:12];
      f7 = (rng[30] && (f3 == 3'b000 || f3 == 3'b101)) ? 7'h20 : 7'h00;
      if (rng[0]) begin
        send({f7, rng[24:15], f3, rng[11:7], 7'h33});
      end else if (f3 == 3'b001 || f3 == 3'b101) begin
        send({f7, rng[24:15], f3, rng[11:7], 7'h13});
      end else begin
        send({rng[31:15], f3, rng[11:7], 7'h13});
      end
    end

    // every immediate format with a shift-immediate last
    repeat (N_IMM) begin
      foreach (IMM_OPS[k]) begin
        rng = xorshift32(rng);
        if (IMM_OPS[k] == 7'h13) begin
          send({1'b0, rng[30], 5'd0, rng[24:15], rng[0], 2'b01, rng[11:7], 7'h13});
        end else begin
          send({rng[31:7], IMM_OPS[k]});
        end
      end
    end

    // divide then multiply back to back
    rng = xorshift32(rng);
    send({7'h01, rng[24:15], 1'b1, rng[13:12], rng[11:7], 7'h33});
    rng = xorshift32(rng);
    send({7'h01, rng[24:15], 1'b0, rng[13:12], rng[11:7], 7'h33});
    stall_cycles = 0;
    while (!mul_issue_o) begin
      if (stall_o) begin
        stall_cycles++;
      end
      idle(1);
    end
    assert (stall_cycles == DIV_LAT)
      else report_mismatch("stall_o cycles", stall_cycles, DIV_LAT);
    idle(1);
    // alu right behind a divide goes straight through
    rng = xorshift32(rng);
    send({7'h01, rng[24:15], 3'b101, rng[11:7], 7'h33});
    send({7'h00, rng[24:15], 3'b000, rng[11:7], 7'h33});
    idle(DIV_LAT + 1);

    // csr variants then privileged ops
    for (int k = 1; k < 8; k++) begin
      if (k != 4) begin
        rng = xorshift32(rng);
        send({rng[31:15], 3'(k), rng[11:7], 7'h73});
      end
    end
    send(32'h3020_0073);
    send(32'h0000_0073);
    send(32'h0010_0073);
    send(32'h1050_0073);

    // unknown opcode, bad funct7, self jump
    rng = xorshift32(rng);
    send({rng[31:7], 7'h0b});
    send({7'h03, rng[24:15], 3'b000, rng[11:7], 7'h33});
    send(32'h0000_006f);
    idle(2);

    $display("%0d instructions sent, %0d errors", sent, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* source/control_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module control_unit #(
  parameter bit HALT_ON_SELF_JUMP = 1'b1
) (
  control_unit_if.decoder cu_if
);

  logic [2:0] funct3;
  logic [6:0] funct7;
  logic is_regreg;
  logic is_shift_imm;
  logic base_wen;

  assign funct3 = cu_if.instr[14:12];
  assign funct7 = cu_if.instr[31:25];

  assign cu_if.opcode = rv_decode_pkg::opcode_t'(cu_if.instr[6:0]);
  assign is_regreg = (cu_if.opcode == rv_decode_pkg::REGREG);

  // register fields sit at fixed positions in every format
  assign cu_if.rs1 = cu_if.instr[19:15];
  assign cu_if.rs2 = cu_if.instr[24:20];
  assign cu_if.rd  = cu_if.instr[11:7];

  // slli, srli, srai
  assign is_shift_imm = (cu_if.opcode == rv_decode_pkg::IMMED) &&
                        (funct3 == 3'b001 || funct3 == 3'b101);

  // immediate selection by format
  always_comb begin
    cu_if.imm = '0;
    if (is_shift_imm) begin
      cu_if.imm = {27'd0, cu_if.instr[24:20]};
    end else begin
      case (cu_if.opcode)
        rv_decode_pkg::IMMED,
        rv_decode_pkg::LOAD,
        rv_decode_pkg::JALR:
          cu_if.imm = {{20{cu_if.instr[31]}}, cu_if.instr[31:20]};
        rv_decode_pkg::STORE:
          cu_if.imm = {{20{cu_if.instr[31]}}, cu_if.instr[31:25], cu_if.instr[11:7]};
        rv_decode_pkg::BRANCH:
          cu_if.imm = {{19{cu_if.instr[31]}}, cu_if.instr[31], cu_if.instr[7],
                       cu_if.instr[30:25], cu_if.instr[11:8], 1'b0};
        rv_decode_pkg::LUI,
        rv_decode_pkg::AUIPC:
          cu_if.imm = {cu_if.instr[31:12], 12'd0};
        rv_decode_pkg::JAL:
          cu_if.imm = {{11{cu_if.instr[31]}}, cu_if.instr[31], cu_if.instr[19:12],
                       cu_if.instr[20], cu_if.instr[30:21], 1'b0};
        default:
          cu_if.imm = '0;
      endcase
    end
  end

  // alu operation defaults to add outside reg-reg and reg-imm
  always_comb begin
    cu_if.alu_op = rv_decode_pkg::ALU_ADD;
    if (is_regreg || cu_if.opcode == rv_decode_pkg::IMMED) begin
      case (funct3)
        3'b000: cu_if.alu_op = (is_regreg && cu_if.instr[30]) ? rv_decode_pkg::ALU_SUB
                                                               : rv_decode_pkg::ALU_ADD;
        3'b001: cu_if.alu_op = rv_decode_pkg::ALU_SLL;
        3'b010: cu_if.alu_op = rv_decode_pkg::ALU_SLT;
        3'b011: cu_if.alu_op = rv_decode_pkg::ALU_SLTU;
        3'b100: cu_if.alu_op = rv_decode_pkg::ALU_XOR;
        3'b101: cu_if.alu_op = cu_if.instr[30] ? rv_decode_pkg::ALU_SRA
                                               : rv_decode_pkg::ALU_SRL;
        3'b110: cu_if.alu_op = rv_decode_pkg::ALU_OR;
        default: cu_if.alu_op = rv_decode_pkg::ALU_AND;
      endcase
    end
  end

  // m extension lives under reg-reg with funct7 0000001
  always_comb begin
    cu_if.fu_type = rv_decode_pkg::FU_ALU;
    if (is_regreg && funct7 == 7'b000_0001) begin
      cu_if.fu_type = funct3[2] ? rv_decode_pkg::FU_DIV : rv_decode_pkg::FU_MUL;
    end
  end

  always_comb begin
    case (funct3)
      3'b011, 3'b101, 3'b111: cu_if.sign_sel = rv_decode_pkg::UNSIGNED;
      3'b010:                 cu_if.sign_sel = rv_decode_pkg::SIGNED_UNSIGNED;
      default:                cu_if.sign_sel = rv_decode_pkg::SIGNED;
    endcase
  end

  assign cu_if.high_sel = |funct3[1:0];
  assign cu_if.div_quot = ~funct3[1];

  // bit 2 of funct3 picks the zimm csr form
  always_comb begin
    cu_if.csr_op = rv_decode_pkg::CSR_NONE;
    if (cu_if.opcode == rv_decode_pkg::SYSTEM) begin
      case (funct3[1:0])
        2'b01:   cu_if.csr_op = rv_decode_pkg::CSR_SWAP;
        2'b10:   cu_if.csr_op = rv_decode_pkg::CSR_SET;
        2'b11:   cu_if.csr_op = rv_decode_pkg::CSR_CLR;
        default: cu_if.csr_op = rv_decode_pkg::CSR_NONE;
      endcase
    end
  end

  assign cu_if.csr_imm = funct3[2] && (cu_if.csr_op != rv_decode_pkg::CSR_NONE);

  // privileged ops are identified by the funct12 field
  always_comb begin
    cu_if.priv_op = rv_decode_pkg::PRIV_NONE;
    if (cu_if.opcode == rv_decode_pkg::SYSTEM && funct3 == 3'b000) begin
      case (cu_if.instr[31:20])
        12'h000: cu_if.priv_op = rv_decode_pkg::PRIV_ECALL;
        12'h001: cu_if.priv_op = rv_decode_pkg::PRIV_EBREAK;
        12'h105: cu_if.priv_op = rv_decode_pkg::PRIV_WFI;
        12'h302: cu_if.priv_op = rv_decode_pkg::PRIV_MRET;
        default: cu_if.priv_op = rv_decode_pkg::PRIV_NONE;
      endcase
    end
  end

  always_comb begin
    case (cu_if.opcode)
      rv_decode_pkg::LOAD:   cu_if.w_src = rv_decode_pkg::WB_LOAD;
      rv_decode_pkg::JAL,
      rv_decode_pkg::JALR:   cu_if.w_src = rv_decode_pkg::WB_PC4;
      rv_decode_pkg::LUI:    cu_if.w_src = rv_decode_pkg::WB_IMM;
      rv_decode_pkg::IMMED,
      rv_decode_pkg::AUIPC,
      rv_decode_pkg::REGREG: cu_if.w_src = rv_decode_pkg::WB_ALU;
      rv_decode_pkg::SYSTEM: cu_if.w_src = rv_decode_pkg::WB_CSR;
      default:               cu_if.w_src = rv_decode_pkg::WB_LOAD;
    endcase
  end

  always_comb begin
    case (cu_if.opcode)
      rv_decode_pkg::IMMED, rv_decode_pkg::LUI, rv_decode_pkg::AUIPC,
      rv_decode_pkg::REGREG, rv_decode_pkg::JAL, rv_decode_pkg::JALR,
      rv_decode_pkg::LOAD:   base_wen = 1'b1;
      rv_decode_pkg::SYSTEM: base_wen = (cu_if.csr_op != rv_decode_pkg::CSR_NONE);
      default:               base_wen = 1'b0;
    endcase
  end

  always_comb begin
    case (cu_if.opcode)
      rv_decode_pkg::REGREG:
        cu_if.illegal = funct7[0] && (funct7 != 7'b000_0001);
      rv_decode_pkg::LUI, rv_decode_pkg::AUIPC, rv_decode_pkg::JAL,
      rv_decode_pkg::JALR, rv_decode_pkg::BRANCH, rv_decode_pkg::LOAD,
      rv_decode_pkg::STORE, rv_decode_pkg::IMMED, rv_decode_pkg::SYSTEM,
      rv_decode_pkg::MISCMEM:
        cu_if.illegal = 1'b0;
      default:
        cu_if.illegal = 1'b1;
    endcase
  end

  // never write back on an illegal encoding
  assign cu_if.wen = base_wen && !cu_if.illegal;

  // a jal to itself spins forever and marks the end of a program
  assign cu_if.halt = HALT_ON_SELF_JUMP && (cu_if.instr == 32'h0000_006f);

endmodule

`default_nettype wire

/* source/control_unit_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface control_unit_if;

  logic [rv_decode_pkg::WORD_W-1:0] instr;

  rv_decode_pkg::opcode_t opcode;
  rv_decode_pkg::alu_op_t alu_op;
  rv_decode_pkg::fu_type_t fu_type;
  rv_decode_pkg::sign_t sign_sel;
  // upper half of the product
  logic high_sel;
  // quotient when set, remainder otherwise
  logic div_quot;

  rv_decode_pkg::w_src_t w_src;
  logic wen;
  logic [rv_decode_pkg::REG_ADDR_W-1:0] rs1;
  logic [rv_decode_pkg::REG_ADDR_W-1:0] rs2;
  logic [rv_decode_pkg::REG_ADDR_W-1:0] rd;
  logic [rv_decode_pkg::WORD_W-1:0] imm;

  rv_decode_pkg::csr_op_t csr_op;
  logic csr_imm;

  rv_decode_pkg::priv_op_t priv_op;
  logic illegal;
  logic halt;

  modport decoder (
    input  instr,
    output opcode, alu_op, fu_type, sign_sel, high_sel, div_quot,
    output w_src, wen, rs1, rs2, rd, imm,
    output csr_op, csr_imm, priv_op, illegal, halt
  );

  modport capture (
    input instr,
    input opcode, alu_op, fu_type, sign_sel, high_sel, div_quot,
    input w_src, wen, rs1, rs2, rd, imm,
    input csr_op, csr_imm, priv_op, illegal, halt
  );

endinterface

`default_nettype wire

/* source/decode_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_reg (
  input  logic                                 CLK,
  input  logic                                 rst_n_i,
  input  logic                                 instr_valid_i,
  input  logic                                 stall_i,
  control_unit_if.capture                      cu_if,
  output logic                                 valid_o,
  output rv_decode_pkg::alu_op_t               alu_op_o,
  output rv_decode_pkg::fu_type_t              fu_type_o,
  output rv_decode_pkg::w_src_t                w_src_o,
  output logic                                 wen_o,
  output logic [rv_decode_pkg::REG_ADDR_W-1:0] rs1_o,
  output logic [rv_decode_pkg::REG_ADDR_W-1:0] rs2_o,
  output logic [rv_decode_pkg::REG_ADDR_W-1:0] rd_o,
  output logic [rv_decode_pkg::WORD_W-1:0]     imm_o,
  output rv_decode_pkg::csr_op_t               csr_op_o,
  output logic                                 csr_imm_o,
  output rv_decode_pkg::priv_op_t              priv_op_o,
  output logic                                 illegal_o,
  output logic                                 halt_o
);

  logic load;
  logic wen_q;

  assign load = instr_valid_i && !stall_i;

  // control state
  always_ff @(posedge CLK) begin
    if (!rst_n_i) begin
      valid_o   <= 1'b0;
      illegal_o <= 1'b0;
      halt_o    <= 1'b0;
    end else if (!stall_i) begin
      valid_o <= instr_valid_i;
      if (instr_valid_i) begin
        illegal_o <= cu_if.illegal;
        halt_o    <= cu_if.halt;
      end
    end
  end

  // payload, held through stalls and bubbles
  always_ff @(posedge CLK) begin
    if (load) begin
      alu_op_o  <= cu_if.alu_op;
      fu_type_o <= cu_if.fu_type;
      w_src_o   <= cu_if.w_src;
      wen_q     <= cu_if.wen;
      rs1_o     <= cu_if.rs1;
      rs2_o     <= cu_if.rs2;
      rd_o      <= cu_if.rd;
      imm_o     <= cu_if.imm;
      csr_op_o  <= cu_if.csr_op;
      csr_imm_o <= cu_if.csr_imm;
      priv_op_o <= cu_if.priv_op;
    end
  end

  // a bubble never writes the register file
  assign wen_o = valid_o && wen_q;

  valid_known_a: assert property (@(posedge CLK) disable iff (!rst_n_i)
    !$isunknown(valid_o))
    else $error("valid_o unknown after reset");

endmodule

`default_nettype wire

/* source/decode_top.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_top #(
  parameter bit          HALT_ON_SELF_JUMP = 1'b1,
  parameter int unsigned DIV_LATENCY       = 4
) (
  input  logic                                 CLK,
  input  logic                                 rst_n_i,
  input  logic [rv_decode_pkg::WORD_W-1:0]     instr_i,
  input  logic                                 instr_valid_i,
  output logic                                 valid_o,
  output rv_decode_pkg::alu_op_t               alu_op_o,
  output rv_decode_pkg::fu_type_t              fu_type_o,
  output rv_decode_pkg::w_src_t                w_src_o,
  output logic                                 wen_o,
  output logic [rv_decode_pkg::REG_ADDR_W-1:0] rs1_o,
  output logic [rv_decode_pkg::REG_ADDR_W-1:0] rs2_o,
  output logic [rv_decode_pkg::REG_ADDR_W-1:0] rd_o,
  output logic [rv_decode_pkg::WORD_W-1:0]     imm_o,
  output rv_decode_pkg::csr_op_t               csr_op_o,
  output logic                                 csr_imm_o,
  output rv_decode_pkg::priv_op_t              priv_op_o,
  output logic                                 illegal_o,
  output logic                                 halt_o,
  output logic                                 alu_issue_o,
  output logic                                 mul_issue_o,
  output logic                                 div_issue_o,
  output logic                                 stall_o
);

  control_unit_if cu_if ();

  assign cu_if.instr = instr_i;

  control_unit #(
    .HALT_ON_SELF_JUMP(HALT_ON_SELF_JUMP)
  ) control_unit_inst (
    .cu_if(cu_if.decoder)
  );

  // stall from the dispatcher freezes the decode register
  decode_reg decode_reg_inst (
    .CLK          (CLK),
    .rst_n_i      (rst_n_i),
    .instr_valid_i(instr_valid_i),
    .stall_i      (stall_o),
    .cu_if        (cu_if.capture),
    .valid_o      (valid_o),
    .alu_op_o     (alu_op_o),
    .fu_type_o    (fu_type_o),
    .w_src_o      (w_src_o),
    .wen_o        (wen_o),
    .rs1_o        (rs1_o),
    .rs2_o        (rs2_o),
    .rd_o         (rd_o),
    .imm_o        (imm_o),
    .csr_op_o     (csr_op_o),
    .csr_imm_o    (csr_imm_o),
    .priv_op_o    (priv_op_o),
    .illegal_o    (illegal_o),
    .halt_o       (halt_o)
  );

  fu_dispatch #(
    .DIV_LATENCY(DIV_LATENCY)
  ) fu_dispatch_inst (
    .CLK        (CLK),
    .rst_n_i    (rst_n_i),
    .valid_i    (valid_o),
    .fu_type_i  (fu_type_o),
    .alu_issue_o(alu_issue_o),
    .mul_issue_o(mul_issue_o),
    .div_issue_o(div_issue_o),
    .stall_o    (stall_o)
  );

endmodule

`default_nettype wire

/* source/fu_dispatch.sv */
`timescale 1ns/1ps
`default_nettype none

module fu_dispatch #(
  parameter int unsigned DIV_LATENCY = 4
) (
  input  logic                    CLK,
  input  logic                    rst_n_i,
  input  logic                    valid_i,
  input  rv_decode_pkg::fu_type_t fu_type_i,
  output logic                    alu_issue_o,
  output logic                    mul_issue_o,
  output logic                    div_issue_o,
  output logic                    stall_o
);

  localparam int CNT_W = $clog2(DIV_LATENCY + 1);

  logic [CNT_W-1:0] div_cnt;
  logic div_busy;
  logic is_mul;
  logic is_div;

  assign div_busy = (div_cnt != '0);
  assign is_mul = (fu_type_i == rv_decode_pkg::FU_MUL);
  assign is_div = (fu_type_i == rv_decode_pkg::FU_DIV);

  // mul and div share the divider datapath so only they wait
  assign stall_o = valid_i && (is_mul || is_div) && div_busy;

  assign alu_issue_o = valid_i && (fu_type_i == rv_decode_pkg::FU_ALU);
  assign mul_issue_o = valid_i && is_mul && !div_busy;
  assign div_issue_o = valid_i && is_div && !div_busy;

  // divider occupancy
  always_ff @(posedge CLK) begin
    if (!rst_n_i) begin
      div_cnt <= '0;
    end else if (div_issue_o) begin
      div_cnt <= CNT_W'(DIV_LATENCY);
    end else if (div_busy) begin
      div_cnt <= div_cnt - 1'b1;
    end
  end

  // the decode register keeps a stalled instruction in place
  stall_hold_a: assert property (@(posedge CLK) disable iff (!rst_n_i)
    stall_o |=> valid_i && $stable(fu_type_i))
    else $error("stalled instruction not held");

endmodule

`default_nettype wire

/* source/rv_decode_pkg.sv */
`default_nettype none

package rv_decode_pkg;

  // instruction and immediate width
  parameter int WORD_W = 32;
  parameter int REG_ADDR_W = 5;

  // major rv32 opcodes
  typedef enum logic [6:0] {
    LOAD    = 7'b000_0011,
    MISCMEM = 7'b000_1111,
    IMMED   = 7'b001_0011,
    AUIPC   = 7'b001_0111,
    STORE   = 7'b010_0011,
    REGREG  = 7'b011_0011,
    LUI     = 7'b011_0111,
    BRANCH  = 7'b110_0011,
    JALR    = 7'b110_0111,
    JAL     = 7'b110_1111,
    SYSTEM  = 7'b111_0011
  } opcode_t;

  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SRL  = 4'd3,
    ALU_SRA  = 4'd4,
    ALU_AND  = 4'd5,
    ALU_OR   = 4'd6,
    ALU_XOR  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9
  } alu_op_t;

  // functional unit class
  typedef enum logic [1:0] {
    FU_ALU = 2'd0,
    FU_MUL = 2'd1,
    FU_DIV = 2'd2
  } fu_type_t;

  // write-back source
  typedef enum logic [2:0] {
    WB_LOAD = 3'd0,
    WB_PC4  = 3'd1,
    WB_IMM  = 3'd2,
    WB_ALU  = 3'd3,
    WB_CSR  = 3'd4
  } w_src_t;

  typedef enum logic [1:0] {
    CSR_NONE = 2'd0,
    CSR_SWAP = 2'd1,
    CSR_SET  = 2'd2,
    CSR_CLR  = 2'd3
  } csr_op_t;

  typedef enum logic [2:0] {
    PRIV_NONE   = 3'd0,
    PRIV_MRET   = 3'd1,
    PRIV_ECALL  = 3'd2,
    PRIV_EBREAK = 3'd3,
    PRIV_WFI    = 3'd4
  } priv_op_t;

  // operand signedness for mul and div
  typedef enum logic [1:0] {
    SIGNED          = 2'd0,
    UNSIGNED        = 2'd1,
    SIGNED_UNSIGNED = 2'd2
  } sign_t;

endpackage

`default_nettype wire

/* tb.f */
+incdir+sim
source/rv_decode_pkg.sv
source/control_unit_if.sv
source/control_unit.sv
source/decode_reg.sv
source/fu_dispatch.sv
source/decode_top.sv
sim/tb_decode_top.sv
